//--- if_fetch_pkg.sv
// instruction fetch stage package
// shared widths, next-PC and exception-vector selects, bus and queue structs

package if_fetch_pkg;

  ////////////////////////////////////////////////////////////
  // widths and constants
  ////////////////////////////////////////////////////////////

  // data and address width
  parameter int unsigned XLEN = 32;
  // low address bits replaced in mtvec and boot addresses
  parameter int unsigned MTVEC_LSB = 8;
  // low byte of the boot fetch address
  parameter logic [7:0] BOOT_OFFSET = 8'h80;

  typedef logic [XLEN-1:0] addr_t;
  // vectored interrupt number
  typedef logic [4:0] irq_id_t;

  ////////////////////////////////////////////////////////////
  // selects
  ////////////////////////////////////////////////////////////

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // source of the exception vector
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  ////////////////////////////////////////////////////////////
  // bus and queue
  ////////////////////////////////////////////////////////////

  // instruction bus request, held until granted
  typedef struct packed {
    logic  req;
    addr_t addr;
  } instr_bus_req_t;

  // instruction bus grant and in-order response
  typedef struct packed {
    logic            gnt;
    logic            rvalid;
    logic [XLEN-1:0] rdata;
    logic            err;
  } instr_bus_rsp_t;

  // one fetched word on its way to decode
  typedef struct packed {
    addr_t           addr;
    logic [XLEN-1:0] rdata;
    logic            err;
  } fetch_entry_t;

endpackage

//--- if_pc_select.sv
// next fetch address selection
// builds the exception vector from mtvec or the debug addresses and then
// picks the next PC from boot, jump, exception, mepc or depc

`timescale 1ns/100ps

module if_pc_select #(
  parameter if_fetch_pkg::addr_t DM_HALT_ADDR      = 32'h1A11_0800,
  parameter if_fetch_pkg::addr_t DM_EXCEPTION_ADDR = 32'h1A11_0808
) (
  input  if_fetch_pkg::addr_t       boot_addr_i,
  input  if_fetch_pkg::addr_t       branch_target_i,
  input  if_fetch_pkg::addr_t       csr_mepc_i,
  input  if_fetch_pkg::addr_t       csr_depc_i,
  input  if_fetch_pkg::addr_t       csr_mtvec_i,
  input  if_fetch_pkg::pc_sel_e     pc_mux_i,
  input  if_fetch_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  if_fetch_pkg::irq_id_t     irq_id_i,
  output if_fetch_pkg::addr_t       fetch_addr_o
);

  if_fetch_pkg::addr_t exc_pc;
  if_fetch_pkg::addr_t boot_pc;
  if_fetch_pkg::addr_t next_pc;

  // upper boot bits with the fixed boot offset
  assign boot_pc = {boot_addr_i[if_fetch_pkg::XLEN-1:if_fetch_pkg::MTVEC_LSB],
                    if_fetch_pkg::BOOT_OFFSET};

  ////////////////////////////////////////////////////////////
  // exception vector
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (exc_pc_mux_i)
      // vectored mode, one word per interrupt line
      if_fetch_pkg::EXC_PC_IRQ: begin
        exc_pc = {csr_mtvec_i[if_fetch_pkg::XLEN-1:if_fetch_pkg::MTVEC_LSB],
                  1'b0, irq_id_i, 2'b00};
      end
      if_fetch_pkg::EXC_PC_DBD:     exc_pc = DM_HALT_ADDR;
      if_fetch_pkg::EXC_PC_DBG_EXC: exc_pc = DM_EXCEPTION_ADDR;
      // synchronous exceptions land on the mtvec base
      default: begin
        exc_pc = {csr_mtvec_i[if_fetch_pkg::XLEN-1:if_fetch_pkg::MTVEC_LSB], 8'h00};
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // next-PC mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (pc_mux_i)
      if_fetch_pkg::PC_JUMP: next_pc = branch_target_i;
      if_fetch_pkg::PC_EXC:  next_pc = exc_pc;
      // return from trap handler
      if_fetch_pkg::PC_ERET: next_pc = csr_mepc_i;
      // return from debug mode
      if_fetch_pkg::PC_DRET: next_pc = csr_depc_i;
      default:               next_pc = boot_pc;
    endcase
  end

  // only whole words are fetched
  assign fetch_addr_o = {next_pc[if_fetch_pkg::XLEN-1:2], 2'b00};

endmodule

//--- if_prefetch_buffer.sv
// prefetch buffer for whole instruction words
// issues in-order bus requests, tracks outstanding and discarded responses
// and queues returned words with their address and error flag

`timescale 1ns/100ps

module if_prefetch_buffer #(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          req_i,
  input  logic                          branch_i,
  input  if_fetch_pkg::addr_t           branch_addr_i,
  input  if_fetch_pkg::instr_bus_rsp_t  bus_rsp_i,
  input  logic                          ready_i,
  output if_fetch_pkg::instr_bus_req_t  bus_req_o,
  output logic                          valid_o,
  output if_fetch_pkg::fetch_entry_t    entry_o,
  output if_fetch_pkg::addr_t           next_pc_o,
  output logic                          busy_o
);

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [CNT_W-1:0] DEPTH_C = CNT_W'(FIFO_DEPTH);
  localparam logic [CNT_W-1:0] ONE_C = CNT_W'(1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);
  localparam if_fetch_pkg::addr_t WORD_INCR = if_fetch_pkg::addr_t'(4);

  if_fetch_pkg::addr_t        req_addr_q, req_addr_d;
  if_fetch_pkg::addr_t        rsp_addr_q;
  if_fetch_pkg::addr_t        next_pc_q;
  logic [CNT_W-1:0]           out_q, out_d;
  logic [CNT_W-1:0]           disc_q, disc_d;
  logic [CNT_W-1:0]           count_q, count_d;
  logic [CNT_W:0]             occupancy;
  logic [PTR_W-1:0]           rd_ptr_q, wr_ptr_q;
  if_fetch_pkg::fetch_entry_t queue_q [FIFO_DEPTH];
  logic                       slot_free;
  logic                       granted;
  logic                       rsp_keep;
  logic                       pop;

  // circular pointer step for any depth
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == LAST_PTR) ? '0 : ptr + PTR_W'(1);
  endfunction

  ////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////

  // every outstanding response owns a queue slot
  assign occupancy = {1'b0, out_q} + {1'b0, count_q};

  always_comb begin
    if (branch_i) begin
      // queue is flushed this cycle, only outstanding responses count
      slot_free = (out_q < DEPTH_C);
    end else begin
      slot_free = (occupancy < {1'b0, DEPTH_C});
    end
  end

  // a redirect goes straight onto the bus
  assign bus_req_o.req  = req_i & slot_free;
  assign bus_req_o.addr = branch_i ? branch_addr_i : req_addr_q;
  assign granted        = bus_req_o.req & bus_rsp_i.gnt;

  always_comb begin
    req_addr_d = req_addr_q;
    if (granted) begin
      req_addr_d = bus_req_o.addr + WORD_INCR;
    end else if (branch_i) begin
      req_addr_d = branch_addr_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // outstanding and discarded responses
  ////////////////////////////////////////////////////////////

  always_comb begin
    out_d = out_q;
    if (granted && !bus_rsp_i.rvalid) begin
      out_d = out_q + ONE_C;
    end else if (!granted && bus_rsp_i.rvalid) begin
      out_d = out_q - ONE_C;
    end
  end

  // on redirect everything still in flight is stale
  // a response in the redirect cycle itself is dropped directly
  always_comb begin
    disc_d = disc_q;
    if (branch_i) begin
      disc_d = bus_rsp_i.rvalid ? out_q - ONE_C : out_q;
    end else if (bus_rsp_i.rvalid && disc_q != '0) begin
      disc_d = disc_q - ONE_C;
    end
  end

  assign rsp_keep = bus_rsp_i.rvalid & (disc_q == '0) & ~branch_i;
  assign busy_o   = (out_q != '0);

  ////////////////////////////////////////////////////////////
  // fetch queue
  ////////////////////////////////////////////////////////////

  assign valid_o   = (count_q != '0);
  assign pop       = valid_o & ready_i;
  assign entry_o   = queue_q[rd_ptr_q];
  assign next_pc_o = next_pc_q;

  always_comb begin
    count_d = count_q;
    if (branch_i) begin
      count_d = '0;
    end else if (rsp_keep && !pop) begin
      count_d = count_q + ONE_C;
    end else if (!rsp_keep && pop) begin
      count_d = count_q - ONE_C;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_addr_q <= '0;
      rsp_addr_q <= '0;
      next_pc_q  <= '0;
      out_q      <= '0;
      disc_q     <= '0;
      count_q    <= '0;
      rd_ptr_q   <= '0;
      wr_ptr_q   <= '0;
    end else begin
      req_addr_q <= req_addr_d;
      out_q      <= out_d;
      disc_q     <= disc_d;
      count_q    <= count_d;
      if (branch_i) begin
        // kept responses and delivery both restart at the target
        rsp_addr_q <= branch_addr_i;
        next_pc_q  <= branch_addr_i;
        rd_ptr_q   <= '0;
        wr_ptr_q   <= '0;
      end else begin
        if (rsp_keep) begin
          rsp_addr_q <= rsp_addr_q + WORD_INCR;
          wr_ptr_q   <= ptr_inc(wr_ptr_q);
        end
        if (pop) begin
          next_pc_q <= next_pc_q + WORD_INCR;
          rd_ptr_q  <= ptr_inc(rd_ptr_q);
        end
      end
    end
  end

  // queue storage
  always_ff @(posedge clk_i) begin
    if (rsp_keep) begin
      queue_q[wr_ptr_q] <= '{addr: rsp_addr_q, rdata: bus_rsp_i.rdata, err: bus_rsp_i.err};
    end
  end

endmodule

//--- if_id_register.sv
// IF-ID pipeline register
// holds the valid and new flags plus instruction, PC and fetch error for decode

`timescale 1ns/100ps

module if_id_register (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              fetch_valid_i,
  input  if_fetch_pkg::fetch_entry_t        entry_i,
  input  logic                              id_in_ready_i,
  input  logic                              pc_set_i,
  input  logic                              instr_valid_clear_i,
  output logic                              fetch_ready_o,
  output logic                              instr_valid_id_o,
  output logic                              instr_new_id_o,
  output logic [if_fetch_pkg::XLEN-1:0]     instr_rdata_id_o,
  output logic                              instr_fetch_err_o,
  output if_fetch_pkg::addr_t               pc_id_o
);

  logic transfer;
  logic valid_d, valid_q;
  logic new_q;

  // decode pulls directly from the queue
  assign fetch_ready_o = id_in_ready_i;
  assign transfer      = fetch_valid_i & id_in_ready_i;

  ////////////////////////////////////////////////////////////
  // flags
  ////////////////////////////////////////////////////////////

  // a redirect squashes the word taken in the same cycle
  // valid is held until decode clears it
  assign valid_d = (transfer & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      // one-cycle marker for every word entering ID
      new_q   <= transfer;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

  ////////////////////////////////////////////////////////////
  // payload
  ////////////////////////////////////////////////////////////

  // frozen while decode is stalled
  always_ff @(posedge clk_i) begin
    if (transfer) begin
      instr_rdata_id_o  <= entry_i.rdata;
      instr_fetch_err_o <= entry_i.err;
      pc_id_o           <= entry_i.addr;
    end
  end

endmodule

//--- if_pc_check.sv
// sequential PC check
// raises an alert when the fetch PC is not the ID PC plus one word

`timescale 1ns/100ps

module if_pc_check #(
  parameter bit PC_INCR_CHECK = 1'b1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                instr_new_i,
  input  logic                redirect_i,
  input  if_fetch_pkg::addr_t pc_if_i,
  input  if_fetch_pkg::addr_t pc_id_i,
  output logic                alert_o
);

  if (PC_INCR_CHECK) begin : g_check
    logic                seq_q;
    logic                redirect_q;
    if_fetch_pkg::addr_t pc_id_incr;

    // a word squashed by a redirect does not start a sequence
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        seq_q      <= 1'b0;
        redirect_q <= 1'b0;
      end else begin
        seq_q      <= (seq_q | (instr_new_i & ~redirect_q)) & ~redirect_i;
        redirect_q <= redirect_i;
      end
    end

    assign pc_id_incr = pc_id_i + if_fetch_pkg::addr_t'(4);
    assign alert_o    = seq_q & (pc_if_i != pc_id_incr);
  end else begin : g_no_check
    assign alert_o = 1'b0;
  end

endmodule

//--- if_fetch_stage.sv
// instruction fetch stage top level
// next-PC selection, prefetch buffer, IF-ID register and PC sequence check

`timescale 1ns/100ps

module if_fetch_stage #(
  parameter if_fetch_pkg::addr_t DM_HALT_ADDR      = 32'h1A11_0800,
  parameter if_fetch_pkg::addr_t DM_EXCEPTION_ADDR = 32'h1A11_0808,
  parameter int unsigned         FIFO_DEPTH        = 2,
  parameter bit                  PC_INCR_CHECK     = 1'b1
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          req_i,
  input  if_fetch_pkg::addr_t           boot_addr_i,
  // instruction bus
  output if_fetch_pkg::instr_bus_req_t  instr_bus_req_o,
  input  if_fetch_pkg::instr_bus_rsp_t  instr_bus_rsp_i,
  // redirect control
  input  logic                          pc_set_i,
  input  if_fetch_pkg::pc_sel_e         pc_mux_i,
  input  if_fetch_pkg::exc_pc_sel_e     exc_pc_mux_i,
  input  if_fetch_pkg::irq_id_t         irq_id_i,
  input  if_fetch_pkg::addr_t           branch_target_ex_i,
  input  if_fetch_pkg::addr_t           csr_mepc_i,
  input  if_fetch_pkg::addr_t           csr_depc_i,
  input  if_fetch_pkg::addr_t           csr_mtvec_i,
  // decode side
  input  logic                          id_in_ready_i,
  input  logic                          instr_valid_clear_i,
  output logic                          instr_valid_id_o,
  output logic                          instr_new_id_o,
  output logic [if_fetch_pkg::XLEN-1:0] instr_rdata_id_o,
  output logic                          instr_fetch_err_o,
  output if_fetch_pkg::addr_t           pc_if_o,
  output if_fetch_pkg::addr_t           pc_id_o,
  // status
  output logic                          csr_mtvec_init_o,
  output logic                          pc_mismatch_alert_o,
  output logic                          if_busy_o
);

  if_fetch_pkg::addr_t        fetch_addr_n;
  logic                       fetch_valid;
  logic                       fetch_ready;
  if_fetch_pkg::fetch_entry_t fetch_entry;

  // mtvec gets its reset value on the boot jump
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == if_fetch_pkg::PC_BOOT);

  if_pc_select #(
    .DM_HALT_ADDR      (DM_HALT_ADDR),
    .DM_EXCEPTION_ADDR (DM_EXCEPTION_ADDR)
  ) u_pc_select (
    .boot_addr_i     (boot_addr_i),
    .branch_target_i (branch_target_ex_i),
    .csr_mepc_i      (csr_mepc_i),
    .csr_depc_i      (csr_depc_i),
    .csr_mtvec_i     (csr_mtvec_i),
    .pc_mux_i        (pc_mux_i),
    .exc_pc_mux_i    (exc_pc_mux_i),
    .irq_id_i        (irq_id_i),
    .fetch_addr_o    (fetch_addr_n)
  );

  if_prefetch_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_prefetch_buffer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .branch_i      (pc_set_i),
    .branch_addr_i (fetch_addr_n),
    .bus_rsp_i     (instr_bus_rsp_i),
    .ready_i       (fetch_ready),
    .bus_req_o     (instr_bus_req_o),
    .valid_o       (fetch_valid),
    .entry_o       (fetch_entry),
    .next_pc_o     (pc_if_o),
    .busy_o        (if_busy_o)
  );

  if_id_register u_if_id_register (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid),
    .entry_i             (fetch_entry),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .fetch_ready_o       (fetch_ready),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o)
  );

  if_pc_check #(
    .PC_INCR_CHECK (PC_INCR_CHECK)
  ) u_pc_check (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .instr_new_i (instr_new_id_o),
    .redirect_i  (pc_set_i),
    .pc_if_i     (pc_if_o),
    .pc_id_i     (pc_id_o),
    .alert_o     (pc_mismatch_alert_o)
  );

endmodule

//--- if_fetch_assert.sv
// bus interface checks for the fetch stage
// bound into the top level next to the DUT

`timescale 1ns/100ps

module if_fetch_assert (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic                         pc_set_i,
  input if_fetch_pkg::instr_bus_req_t bus_req_i,
  input if_fetch_pkg::instr_bus_rsp_t bus_rsp_i,
  input logic                         instr_valid_id_i
);

  // request address always known
  a_addr_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_i.req |-> !$isunknown(bus_req_i.addr))
    else $error("request address unknown");

  // whole words only
  a_addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_i.req |-> bus_req_i.addr[1:0] == 2'b00)
    else $error("request address not word aligned");

  // held until granted, a redirect may move it
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_i.req && !bus_rsp_i.gnt |=> pc_set_i || (bus_req_i.req && $stable(bus_req_i.addr)))
    else $error("request dropped or changed before grant");

  a_valid_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !instr_valid_id_i)
    else $error("instruction valid right after reset");

endmodule

bind if_fetch_stage if_fetch_assert u_fetch_assert (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .pc_set_i         (pc_set_i),
  .bus_req_i        (instr_bus_req_o),
  .bus_rsp_i        (instr_bus_rsp_i),
  .instr_valid_id_i (instr_valid_id_o)
);

//--- tb_if_fetch_stage.sv
// testbench for the instruction fetch stage
// bus memory model with random grant and response delay, directed tests

`timescale 1ns/100ps

module tb_if_fetch_stage;

  localparam logic [31:0] DATA_KEY = 32'hA5A5_0F0F;
  localparam logic [31:0] ERR_LO   = 32'h0000_2008;
  localparam logic [31:0] ERR_HI   = 32'h0000_200C;
  localparam logic [31:0] DM_HALT  = 32'h0000_0800;
  localparam logic [31:0] DM_EXC   = 32'h0000_0808;
  // about 60 delivered words at up to ~20 cycles each, plus margin
  localparam int TIMEOUT_CYCLES = 3000;

  logic clk_i = 1'b0;
  logic rst_ni, req_i, pc_set_i, id_in_ready_i, instr_valid_clear_i;
  if_fetch_pkg::addr_t boot_addr_i, branch_target_ex_i, csr_mepc_i, csr_depc_i, csr_mtvec_i;
  if_fetch_pkg::pc_sel_e pc_mux_i;
  if_fetch_pkg::exc_pc_sel_e exc_pc_mux_i;
  if_fetch_pkg::irq_id_t irq_id_i;
  if_fetch_pkg::instr_bus_req_t bus_req;
  if_fetch_pkg::instr_bus_rsp_t bus_rsp;
  logic instr_valid_id_o, instr_new_id_o, instr_fetch_err_o;
  logic [31:0] instr_rdata_id_o;
  if_fetch_pkg::addr_t pc_if_o, pc_id_o;
  logic csr_mtvec_init_o, pc_mismatch_alert_o, if_busy_o;

  integer seed = 32'h434e;
  int errors = 0;
  int cycles = 0;
  int mem_cyc = 0;
  logic [31:0] pend_addr[$];
  int pend_due[$];
  int last_due = 0;

  if_fetch_stage #(
    .DM_HALT_ADDR (DM_HALT), .DM_EXCEPTION_ADDR (DM_EXC),
    .FIFO_DEPTH (2), .PC_INCR_CHECK (1'b1)
  ) UUT (
    .clk_i, .rst_ni, .req_i, .boot_addr_i,
    .instr_bus_req_o (bus_req), .instr_bus_rsp_i (bus_rsp),
    .pc_set_i, .pc_mux_i, .exc_pc_mux_i, .irq_id_i,
    .branch_target_ex_i, .csr_mepc_i, .csr_depc_i, .csr_mtvec_i,
    .id_in_ready_i, .instr_valid_clear_i,
    .instr_valid_id_o, .instr_new_id_o, .instr_rdata_id_o, .instr_fetch_err_o,
    .pc_if_o, .pc_id_o, .csr_mtvec_init_o, .pc_mismatch_alert_o, .if_busy_o
  );

  always #20 clk_i = ~clk_i;

  // run limit
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: no end of test after %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // memory model
  ////////////////////////////////////////////////////////////

  // grants at random, answers 1 to 3 cycles later in request order
  always @(posedge clk_i) begin
    int due;
    mem_cyc++;
    if (!rst_ni) begin
      pend_addr.delete();
      pend_due.delete();
    end else begin
      if (bus_rsp.rvalid) begin
        void'(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
      if (bus_req.req && bus_rsp.gnt) begin
        due = mem_cyc + ($unsigned($random(seed)) % 3);
        if (due <= last_due) due = last_due + 1;
        last_due = due;
        pend_addr.push_back(bus_req.addr);
        pend_due.push_back(due);
      end
    end
    #2;
    bus_rsp.gnt    = ($random(seed) & 3) != 0;
    bus_rsp.rvalid = (pend_addr.size() > 0) && (pend_due[0] <= mem_cyc);
    bus_rsp.rdata  = bus_rsp.rvalid ? pend_addr[0] ^ DATA_KEY : '0;
    bus_rsp.err    = bus_rsp.rvalid && pend_addr[0] >= ERR_LO && pend_addr[0] < ERR_HI;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // next drive point, 2 ns after the rising edge
  task automatic tick();
    @(posedge clk_i);
    #2;
  endtask

  task automatic check(input bit cond, input string msg);
    assert (cond) else begin
      errors++;
      $display("ERROR at %0t ns: %s", $time, msg);
    end
  endtask

  task automatic wait_new();
    do tick(); while (!instr_new_id_o);
  endtask

  // decode is held off in the redirect cycle so nothing is squashed
  task automatic redirect(input if_fetch_pkg::pc_sel_e sel, input if_fetch_pkg::exc_pc_sel_e esel);
    pc_set_i      = 1'b1;
    pc_mux_i      = sel;
    exc_pc_mux_i  = esel;
    id_in_ready_i = 1'b0;
    #1;
    // mtvec init belongs to the boot jump only
    check(!csr_mtvec_init_o, "mtvec init high on non-boot redirect");
    tick();
    pc_set_i      = 1'b0;
    id_in_ready_i = 1'b1;
  endtask

  // next word in ID carries the expected PC, data and error
  task automatic check_landing(input logic [31:0] exp_pc, input bit exp_err);
    wait_new();
    check(instr_valid_id_o, "valid low with new instruction");
    check(pc_id_o == exp_pc, $sformatf("pc_id %h expected %h", pc_id_o, exp_pc));
    check(instr_rdata_id_o == (exp_pc ^ DATA_KEY), $sformatf("bad data at %h", exp_pc));
    check(instr_fetch_err_o == exp_err, $sformatf("fetch error flag wrong at %h", exp_pc));
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic test_boot();
    logic [31:0] boot_pc;
    boot_pc = (boot_addr_i & ~32'hFF) | 32'h80;
    check(!bus_req.req && !instr_valid_id_o && !instr_new_id_o, "control high after reset");
    check(!if_busy_o && !pc_mismatch_alert_o, "status high after reset");
    req_i = 1'b1;
    pc_set_i = 1'b1;
    pc_mux_i = if_fetch_pkg::PC_BOOT;
    #1;
    check(csr_mtvec_init_o, "mtvec init low on boot jump");
    check(bus_req.req && bus_req.addr == boot_pc, "no boot request");
    tick();
    pc_set_i = 1'b0;
    check(pc_if_o == boot_pc, $sformatf("pc_if %h expected %h after boot", pc_if_o, boot_pc));
    check_landing(boot_pc, 1'b0);
  endtask

  task automatic test_stream(input int n);
    logic [31:0] exp_pc;
    int got;
    exp_pc = 32'h0000_0100;
    got = 0;
    branch_target_ex_i = exp_pc;
    redirect(if_fetch_pkg::PC_JUMP, if_fetch_pkg::EXC_PC_EXC);
    while (got < n) begin
      tick();
      check(!pc_mismatch_alert_o, "sequence alert while streaming");
      if (instr_new_id_o) begin
        check(pc_id_o == exp_pc, $sformatf("stream pc %h expected %h", pc_id_o, exp_pc));
        check(instr_rdata_id_o == (exp_pc ^ DATA_KEY), "stream data mismatch");
        exp_pc += 4;
        got++;
      end
      id_in_ready_i = ($random(seed) & 1) != 0;
    end
    id_in_ready_i = 1'b1;
  endtask

  // redirect taken while the bus still owes responses
  task automatic test_return(input if_fetch_pkg::pc_sel_e sel, input logic [31:0] target);
    do tick(); while (!if_busy_o);
    redirect(sel, if_fetch_pkg::EXC_PC_EXC);
    check(pc_if_o == target, $sformatf("pc_if %h expected %h after redirect", pc_if_o, target));
    check_landing(target, 1'b0);
    check_landing(target + 4, 1'b0);
  endtask

  task automatic test_exc(input if_fetch_pkg::exc_pc_sel_e esel, input logic [31:0] target);
    redirect(if_fetch_pkg::PC_EXC, esel);
    check(pc_if_o == target, $sformatf("pc_if %h expected %h after trap", pc_if_o, target));
    check_landing(target, 1'b0);
  endtask

  task automatic test_valid_hold();
    logic [31:0] held_pc;
    held_pc = pc_id_o;
    id_in_ready_i = 1'b0;
    repeat (5) begin
      tick();
      check(instr_valid_id_o && pc_id_o == held_pc, "valid or pc lost under stall");
    end
    instr_valid_clear_i = 1'b1;
    tick();
    instr_valid_clear_i = 1'b0;
    check(!instr_valid_id_o, "valid not cleared");
    while (!UUT.u_prefetch_buffer.valid_o) tick();
    // transfer in the same cycle as the redirect
    branch_target_ex_i = 32'h0000_6000;
    pc_set_i = 1'b1;
    pc_mux_i = if_fetch_pkg::PC_JUMP;
    id_in_ready_i = 1'b1;
    tick();
    pc_set_i = 1'b0;
    check(instr_new_id_o && !instr_valid_id_o, "squashed transfer set valid");
    check_landing(32'h0000_6000, 1'b0);
  endtask

  initial begin
    rst_ni = 1'b0;
    req_i = 1'b0;
    pc_set_i = 1'b0;
    id_in_ready_i = 1'b1;
    instr_valid_clear_i = 1'b0;
    boot_addr_i = 32'h0000_1000;
    branch_target_ex_i = '0;
    csr_mepc_i = 32'h0000_4010;
    csr_depc_i = 32'h0000_5020;
    csr_mtvec_i = 32'h0000_7F01;
    pc_mux_i = if_fetch_pkg::PC_BOOT;
    exc_pc_mux_i = if_fetch_pkg::EXC_PC_EXC;
    irq_id_i = 5'd5;
    bus_rsp = '0;
    repeat (3) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    tick();
    test_boot();
    test_stream(40);
    branch_target_ex_i = 32'h0000_3000;
    test_return(if_fetch_pkg::PC_JUMP, 32'h0000_3000);
    test_return(if_fetch_pkg::PC_ERET, 32'h0000_4010);
    test_return(if_fetch_pkg::PC_DRET, 32'h0000_5020);
    test_exc(if_fetch_pkg::EXC_PC_EXC, 32'h0000_7F00);
    test_exc(if_fetch_pkg::EXC_PC_IRQ, 32'h0000_7F14);
    test_exc(if_fetch_pkg::EXC_PC_DBD, DM_HALT);
    test_exc(if_fetch_pkg::EXC_PC_DBG_EXC, DM_EXC);
    // error window covers one word only
    branch_target_ex_i = 32'h0000_2000;
    redirect(if_fetch_pkg::PC_JUMP, if_fetch_pkg::EXC_PC_EXC);
    check_landing(32'h0000_2000, 1'b0);
    check_landing(32'h0000_2004, 1'b0);
    check_landing(32'h0000_2008, 1'b1);
    check_landing(32'h0000_200C, 1'b0);
    test_valid_hold();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- if_fetch_stage.f
if_fetch_pkg.sv
if_pc_select.sv
if_prefetch_buffer.sv
if_id_register.sv
if_pc_check.sv
if_fetch_stage.sv
if_fetch_assert.sv
tb_if_fetch_stage.sv

//--- run_sim.sh
#!/bin/sh
# compile and run with Verilator, result taken from the simulation log
verilator --binary --timing --assert -Wno-fatal --top-module tb_if_fetch_stage \
  -f if_fetch_stage.f -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { echo "build or run failed"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }
